/* dv/cpu_testdata.txt */
# L addr word loads memory, I word sets in_port, R runs to halt, E word is the expected out_port
# values are hex and several records may share a line
# memory arithmetic, 1234 + 0f0f - 0321 stored, cleared and reloaded
L 000 1020  L 001 3021  L 002 5022  L 003 2023
L 004 000b  L 005 1023  L 006 0009  L 007 000d
L 020 1234  L 021 0f0f  L 022 0321
I 0000  R  E 1e22
# accumulator operations ending in or, and, xor against memory
L 000 1030  L 001 000b  L 002 0002  L 003 0001
L 004 0001  L 005 0005  L 006 0006  L 007 0003
L 008 0003  L 009 0004  L 00a 9031  L 00b 8032
L 00c a033  L 00d 0009  L 00e 000d
L 030 1235  L 031 1230  L 032 0ff0  L 033 a5a5
I 0000  R  E a795
# conditional jumps, each path sets its own output bit
L 000 000b  L 001 c004  L 002 0040  L 003 b005
L 004 0041  L 005 0001  L 006 c009  L 007 0042
L 008 b00a  L 009 0043  L 00a d00d  L 00b 0044
L 00c b00e  L 00d 0045  L 00e e011  L 00f 0046
L 010 b012  L 011 0047  L 012 0002  L 013 0002
L 014 d017  L 015 0048  L 016 b018  L 017 0049
L 018 e01b  L 019 004a  L 01a b01c  L 01b 004b
L 01c 000d
I 0000  R  E 0a56
# input word, accumulator bits, output bits and input bit skips
L 000 000a  L 001 0014  L 002 002f  L 003 0020
L 004 0009  L 005 004f  L 006 0052  L 007 0062
L 008 0040  L 009 0061  L 00a 0041  L 00b 006a
L 00c 000c  L 00d 000d
I 8c05  R  E 8c12
# clear output, then a stacked mwo and a dropped opcode as no-ops
L 000 0043  L 001 0047  L 002 000c  L 003 0049
L 004 0409  L 005 4021  L 006 000d
I 0000  R  E 0200

/* filelist.f */
hw/cpu_isa_pkg.sv
hw/cpu_datapath_pkg.sv
hw/cpu_memory.sv
hw/cpu_output_port.sv
hw/cpu_accumulator.sv
hw/cpu_control.sv
hw/cpu_top.sv
dv/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= tb_cpu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_cpu.sv */
// testbench for the accumulator processor with file-driven loads, runs and output checks
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;
    import cpu_datapath_pkg::*;

    localparam int ack_wait_max = 8;
    localparam int settle_cycles = 20;

    logic              clk;
    logic              reset;
    logic              run;
    logic [WORD_W-1:0] in_port;
    logic [WORD_W-1:0] out_port;
    logic              halted;
    logic              load_req;
    logic              load_ack;
    logic [ADDR_W-1:0] load_addr;
    logic [WORD_W-1:0] load_data;

    // records from the data file, in file order
    logic [7:0]        rec_kind[$];
    logic [WORD_W-1:0] rec_a[$];
    logic [WORD_W-1:0] rec_b[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    cpu_top #(
        .mem_words (256)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .in_port   (in_port),
        .out_port  (out_port),
        .halted    (halted),
        .load_req  (load_req),
        .load_ack  (load_ack),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout waiting for halt after %0d cycles", cycle_count);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset    = 1'b1;
        run      = 1'b0;
        load_req = 1'b0;
        repeat (4) begin
            next_cycle();
            check_value("halted", 32'(halted), 32'd0);
            check_value("load_ack", 32'(load_ack), 32'd0);
            check_value("out_port", 32'(out_port), 32'd0);
        end
        reset = 1'b0;
    endtask

    task automatic wait_for_ack(input logic level, output int waited);
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (load_ack !== level && waited < ack_wait_max);
        if (load_ack !== level) begin
            $display("load_ack did not go to %0d within %0d cycles", level, ack_wait_max);
            stop_with_failure();
        end
    endtask

    // four-phase write of one program word
    task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        int waited;
        load_addr = addr;
        load_data = data;
        load_req  = 1'b1;
        wait_for_ack(1'b1, waited);
        check_value("load_ack rise delay", 32'(waited), 32'd1);
        load_req = 1'b0;
        wait_for_ack(1'b0, waited);
        check_value("load_ack fall delay", 32'(waited), 32'd1);
    endtask

    task automatic run_program(input logic [WORD_W-1:0] in_word);
        logic [WORD_W-1:0] halt_word;
        in_port = in_word;
        run     = 1'b1;
        while (!halted) begin
            next_cycle();
        end
        halt_word = out_port;
        // output must hold while halted
        repeat (settle_cycles) begin
            next_cycle();
        end
        check_value("out_port after halt", 32'(out_port), 32'(halt_word));
        check_value("halted", 32'(halted), 32'd1);
        run = 1'b0;
    endtask

    task automatic read_testdata();
        int                fd;
        int                code;
        logic [7:0]        kind;
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic [8*200-1:0]  rest;
        fd = $fopen("dv/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/cpu_testdata.txt");
            stop_with_failure();
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            a = '0;
            b = '0;
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else begin
                case (kind)
                    "L":      code = $fscanf(fd, "%h %h", a, b) - 2;
                    "I", "E": code = $fscanf(fd, "%h", a) - 1;
                    "R":      code = 0;
                    default:  code = -1;
                endcase
                if (code != 0) begin
                    $display("malformed record of kind '%c' in dv/cpu_testdata.txt", kind);
                    stop_with_failure();
                end
                rec_kind.push_back(kind);
                rec_a.push_back(a);
                rec_b.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [WORD_W-1:0] in_word;
        int                n_load;
        int                n_run;
        bit                need_reset;
        reset      = 1'b1;
        run        = 1'b0;
        in_port    = '0;
        load_req   = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        in_word    = '0;
        n_load     = 0;
        n_run      = 0;
        need_reset = 1'b1;

        read_testdata();
        foreach (rec_kind[i]) begin
            if (rec_kind[i] == "L") begin
                n_load++;
            end
            if (rec_kind[i] == "R") begin
                n_run++;
            end
        end
        if (n_run == 0) begin
            $display("no program runs found in dv/cpu_testdata.txt");
            stop_with_failure();
        end
        cycle_limit = 40 * n_load + 200 * n_run;

        for (int i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
                "L": begin
                    // a new program starts from reset
                    if (need_reset) begin
                        apply_reset();
                        need_reset = 1'b0;
                    end
                    load_word(rec_a[i][ADDR_W-1:0], rec_b[i]);
                end
                "I": in_word = rec_a[i];
                "R": run_program(in_word);
                "E": begin
                    check_value("out_port", 32'(out_port), 32'(rec_a[i]));
                    need_reset = 1'b1;
                end
                default: begin
                    $display("unknown record kind '%c'", rec_kind[i]);
                    stop_with_failure();
                end
            endcase
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
// processor top level wiring control, accumulator, memory and output port
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
    parameter int mem_words = 256
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic [cpu_datapath_pkg::WORD_W-1:0] in_port,
    output logic [cpu_datapath_pkg::WORD_W-1:0] out_port,
    output logic                                halted,
    input  logic                                load_req,
    output logic                                load_ack,
    input  logic [cpu_datapath_pkg::ADDR_W-1:0] load_addr,
    input  logic [cpu_datapath_pkg::WORD_W-1:0] load_data
);
    import cpu_datapath_pkg::*;

    logic [ADDR_W-1:0]   mem_addr;
    logic                mem_we;
    logic [WORD_W-1:0]   mem_rdata;
    logic                acc_load;
    logic [ACC_OP_W-1:0] acc_op;
    logic [WORD_W-1:0]   acc_value;
    logic [2:0]          flags;
    logic                out_set;
    logic                out_clear;
    logic                out_move;
    logic                out_clear_all;
    logic [3:0]          out_bit;

    cpu_control i_control (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .mem_rdata     (mem_rdata),
        .flags         (flags),
        .acc_value     (acc_value),
        .in_port       (in_port),
        .mem_addr      (mem_addr),
        .mem_we        (mem_we),
        .acc_load      (acc_load),
        .acc_op        (acc_op),
        .out_set       (out_set),
        .out_clear     (out_clear),
        .out_move      (out_move),
        .out_clear_all (out_clear_all),
        .out_bit       (out_bit),
        .halted        (halted)
    );

    cpu_accumulator i_accumulator (
        .clk       (clk),
        .reset     (reset),
        .acc_load  (acc_load),
        .acc_op    (acc_op),
        .operand   (mem_rdata),
        .in_port   (in_port),
        .acc_value (acc_value),
        .flags     (flags)
    );

    cpu_memory #(
        .mem_words (mem_words)
    ) i_memory (
        .clk       (clk),
        .reset     (reset),
        .addr      (mem_addr),
        .we        (mem_we),
        .wdata     (acc_value),
        .rdata     (mem_rdata),
        .load_req  (load_req),
        .load_ack  (load_ack),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    cpu_output_port i_output_port (
        .clk       (clk),
        .reset     (reset),
        .set       (out_set),
        .clear     (out_clear),
        .move      (out_move),
        .clear_all (out_clear_all),
        .bit_index (out_bit),
        .acc_value (acc_value),
        .out_word  (out_port)
    );

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
// stage counter, program counter, instruction register, decode and halt
`timescale 1ns/100ps
`default_nettype none

module cpu_control (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  run,
    input  logic [cpu_datapath_pkg::WORD_W-1:0]   mem_rdata,
    input  logic [2:0]                            flags,
    input  logic [cpu_datapath_pkg::WORD_W-1:0]   acc_value,
    input  logic [cpu_datapath_pkg::WORD_W-1:0]   in_port,
    output logic [cpu_datapath_pkg::ADDR_W-1:0]   mem_addr,
    output logic                                  mem_we,
    output logic                                  acc_load,
    output logic [cpu_datapath_pkg::ACC_OP_W-1:0] acc_op,
    output logic                                  out_set,
    output logic                                  out_clear,
    output logic                                  out_move,
    output logic                                  out_clear_all,
    output logic [3:0]                            out_bit,
    output logic                                  halted
);
    import cpu_isa_pkg::*;
    import cpu_datapath_pkg::*;

    logic              stage;
    logic              go_exec;
    logic              halt_hit;
    logic              active;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] pc_next;
    instr_u            ir;
    instr_u            fetched;

    assign fetched = mem_rdata;
    assign active  = run && !halted;
    // bit index for BOS and BOC in the fetched word
    assign out_bit = fetched.noarg.sub;

    always_comb begin
        mem_addr      = pc;
        mem_we        = 1'b0;
        acc_load      = 1'b0;
        acc_op        = ACC_NONE;
        out_set       = 1'b0;
        out_clear     = 1'b0;
        out_move      = 1'b0;
        out_clear_all = 1'b0;
        halt_hit      = 1'b0;
        go_exec       = 1'b0;
        pc_next       = pc + ADDR_W'(1);
        if (stage) begin
            // execute stage works on the stored address
            mem_addr = ir.mem.addr;
            pc_next  = pc;
            if (active) begin
                case (ir.mem.opcode)
                    OP_LDW:  acc_load = 1'b1;
                    OP_STW:  mem_we = 1'b1;
                    OP_ADD:  acc_op = ACC_ADD;
                    OP_SUB:  acc_op = ACC_SUB;
                    OP_AND:  acc_op = ACC_AND;
                    OP_OR:   acc_op = ACC_OR;
                    OP_XOR:  acc_op = ACC_XOR;
                    default: acc_op = ACC_NONE;
                endcase
            end
        end else if (active) begin
            case (fetched.mem.opcode)
                OP_LDW, OP_STW, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    go_exec = 1'b1;
                end
                OP_JMP: pc_next = fetched.mem.addr;
                OP_JPZ: if (flags[FLAG_Z]) pc_next = fetched.mem.addr;
                OP_JPC: if (flags[FLAG_C]) pc_next = fetched.mem.addr;
                OP_JPS: if (flags[FLAG_S]) pc_next = fetched.mem.addr;
                OP_NOARG: begin
                    if (fetched.noarg.stack == STK_NONE) begin
                        case (fetched.noarg.bop)
                            // SET/CLR take the index from the word's low bits
                            BOP_BWS: acc_op = ACC_SET;
                            BOP_BWC: acc_op = ACC_CLR;
                            BOP_BOS: out_set = 1'b1;
                            BOP_BOC: out_clear = 1'b1;
                            BOP_BIJ: begin
                                if (in_port[fetched.noarg.sub]) begin
                                    pc_next = pc + ADDR_W'(2);
                                end
                            end
                            BOP_NONE: begin
                                case (fetched.noarg.sub)
                                    SOP_INC: acc_op = ACC_INC;
                                    SOP_DEC: acc_op = ACC_DEC;
                                    SOP_RTL: acc_op = ACC_RTL;
                                    SOP_RTR: acc_op = ACC_RTR;
                                    SOP_NOT: acc_op = ACC_NOT;
                                    SOP_COM: acc_op = ACC_COM;
                                    SOP_MIW: acc_op = ACC_IN_LOAD;
                                    SOP_CLW: acc_op = ACC_CLW;
                                    SOP_MWO: out_move = 1'b1;
                                    SOP_CLO: out_clear_all = 1'b1;
                                    SOP_HLT: halt_hit = 1'b1;
                                    default: acc_op = ACC_NONE;
                                endcase
                            end
                            default: acc_op = ACC_NONE;
                        endcase
                    end
                end
                // dropped opcodes fall through as a no-op
                default: acc_op = ACC_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage  <= 1'b0;
            pc     <= '0;
            halted <= 1'b0;
        end else if (active) begin
            stage <= go_exec;
            pc    <= pc_next;
            if (halt_hit) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && !stage) begin
            ir <= fetched;
        end
    end

    a_no_we_with_load: assert property (
        @(posedge clk) disable iff (reset) !(mem_we && acc_load));

endmodule

`default_nettype wire

/* hw/cpu_accumulator.sv */
// accumulator register, ALU, carry flag and zero/sign flags
`timescale 1ns/100ps
`default_nettype none

module cpu_accumulator (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  acc_load,
    input  logic [cpu_datapath_pkg::ACC_OP_W-1:0] acc_op,
    input  logic [cpu_datapath_pkg::WORD_W-1:0]   operand,
    input  logic [cpu_datapath_pkg::WORD_W-1:0]   in_port,
    output logic [cpu_datapath_pkg::WORD_W-1:0]   acc_value,
    output logic [2:0]                            flags
);
    import cpu_isa_pkg::*;
    import cpu_datapath_pkg::*;

    logic [WORD_W-1:0] acc;
    logic [WORD_W-1:0] acc_next;
    logic              carry;
    logic              carry_next;

    always_comb begin
        acc_next   = acc;
        carry_next = carry;
        if (acc_load) begin
            acc_next = operand;
        end else begin
            case (acc_op)
                ACC_INC: {carry_next, acc_next} = {1'b0, acc} + (WORD_W + 1)'(1);
                ACC_DEC: begin
                    carry_next = (acc == '0);
                    acc_next   = acc - WORD_W'(1);
                end
                ACC_RTL: {carry_next, acc_next} = {acc, 1'b0};
                ACC_RTR: {acc_next, carry_next} = {1'b0, acc};
                ACC_NOT: acc_next = ~acc;
                ACC_COM: acc_next = ~acc + WORD_W'(1);
                ACC_ADD: {carry_next, acc_next} = {1'b0, acc} + {1'b0, operand};
                ACC_SUB: begin
                    // borrow when the operand is larger
                    carry_next = (acc < operand);
                    acc_next   = acc - operand;
                end
                ACC_AND:     acc_next = acc & operand;
                ACC_OR:      acc_next = acc | operand;
                ACC_XOR:     acc_next = acc ^ operand;
                ACC_SET:     acc_next[operand[3:0]] = 1'b1;
                ACC_CLR:     acc_next[operand[3:0]] = 1'b0;
                ACC_CLW:     acc_next = '0;
                ACC_IN_LOAD: acc_next = in_port;
                default:     acc_next = acc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc   <= '0;
            carry <= 1'b0;
        end else begin
            acc   <= acc_next;
            carry <= carry_next;
        end
    end

    assign acc_value     = acc;
    assign flags[FLAG_Z] = (acc == '0);
    assign flags[FLAG_C] = carry;
    assign flags[FLAG_S] = acc[WORD_W-1];

    a_op_defined: assert property (
        @(posedge clk) disable iff (reset) acc_op <= ACC_IN_LOAD);

endmodule

`default_nettype wire

/* hw/cpu_output_port.sv */
// output word register with bit set, bit clear, move and clear-all
`timescale 1ns/100ps
`default_nettype none

module cpu_output_port (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                set,
    input  logic                                clear,
    input  logic                                move,
    input  logic                                clear_all,
    input  logic [3:0]                          bit_index,
    input  logic [cpu_datapath_pkg::WORD_W-1:0] acc_value,
    output logic [cpu_datapath_pkg::WORD_W-1:0] out_word
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_word <= '0;
        end else if (set) begin
            out_word[bit_index] <= 1'b1;
        end else if (clear) begin
            out_word[bit_index] <= 1'b0;
        end else if (move) begin
            out_word <= acc_value;
        end else if (clear_all) begin
            out_word <= '0;
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset) $onehot0({set, clear, move, clear_all}));

endmodule

`default_nettype wire

/* hw/cpu_memory.sv */
// word memory with core read/write port and four-phase load port
`timescale 1ns/100ps
`default_nettype none

module cpu_memory #(
    parameter int mem_words = 256
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [cpu_datapath_pkg::ADDR_W-1:0] addr,
    input  logic                                we,
    input  logic [cpu_datapath_pkg::WORD_W-1:0] wdata,
    output logic [cpu_datapath_pkg::WORD_W-1:0] rdata,
    input  logic                                load_req,
    output logic                                load_ack,
    input  logic [cpu_datapath_pkg::ADDR_W-1:0] load_addr,
    input  logic [cpu_datapath_pkg::WORD_W-1:0] load_data
);
    import cpu_datapath_pkg::*;

    // upper address bits are ignored, so addresses wrap
    localparam int idx_w = $clog2(mem_words);

    logic [WORD_W-1:0] words [mem_words];
    logic              load_write;

    // write once per request, on the edge that raises ack
    assign load_write = load_req && !load_ack;
    assign rdata      = words[addr[idx_w-1:0]];

    always_ff @(posedge clk) begin
        if (we) begin
            words[addr[idx_w-1:0]] <= wdata;
        end else if (load_write) begin
            words[load_addr[idx_w-1:0]] <= load_data;
        end
    end

    // ack tracks req one edge late
    always_ff @(posedge clk) begin
        if (reset) begin
            load_ack <= 1'b0;
        end else begin
            load_ack <= load_req;
        end
    end

    a_no_write_clash: assert property (
        @(posedge clk) disable iff (reset) !(we && load_write));

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (reset) $rose(load_ack) |-> $past(load_req));

endmodule

`default_nettype wire

/* hw/cpu_datapath_pkg.sv */
// word and address widths, accumulator operation codes
`default_nettype none

package cpu_datapath_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 12;

    localparam int ACC_OP_W = 5;

    localparam logic [ACC_OP_W-1:0] ACC_NONE    = 5'd0;
    localparam logic [ACC_OP_W-1:0] ACC_INC     = 5'd1;
    localparam logic [ACC_OP_W-1:0] ACC_DEC     = 5'd2;
    localparam logic [ACC_OP_W-1:0] ACC_RTL     = 5'd3;
    localparam logic [ACC_OP_W-1:0] ACC_RTR     = 5'd4;
    localparam logic [ACC_OP_W-1:0] ACC_NOT     = 5'd5;
    localparam logic [ACC_OP_W-1:0] ACC_COM     = 5'd6;
    localparam logic [ACC_OP_W-1:0] ACC_ADD     = 5'd7;
    localparam logic [ACC_OP_W-1:0] ACC_SUB     = 5'd8;
    localparam logic [ACC_OP_W-1:0] ACC_AND     = 5'd9;
    localparam logic [ACC_OP_W-1:0] ACC_OR      = 5'd10;
    localparam logic [ACC_OP_W-1:0] ACC_XOR     = 5'd11;
    localparam logic [ACC_OP_W-1:0] ACC_SET     = 5'd12;
    localparam logic [ACC_OP_W-1:0] ACC_CLR     = 5'd13;
    localparam logic [ACC_OP_W-1:0] ACC_CLW     = 5'd14;
    // highest defined code
    localparam logic [ACC_OP_W-1:0] ACC_IN_LOAD = 5'd15;

endpackage

`default_nettype wire

/* hw/cpu_isa_pkg.sv */
// opcode constants, instruction word union and flag bit positions
`default_nettype none

package cpu_isa_pkg;

    // major opcodes in the top four bits
    localparam logic [3:0] OP_NOARG = 4'b0000;
    localparam logic [3:0] OP_LDW   = 4'b0001;
    localparam logic [3:0] OP_STW   = 4'b0010;
    localparam logic [3:0] OP_ADD   = 4'b0011;
    localparam logic [3:0] OP_SUB   = 4'b0101;
    localparam logic [3:0] OP_AND   = 4'b1000;
    localparam logic [3:0] OP_OR    = 4'b1001;
    localparam logic [3:0] OP_XOR   = 4'b1010;
    localparam logic [3:0] OP_JMP   = 4'b1011;
    localparam logic [3:0] OP_JPZ   = 4'b1100;
    localparam logic [3:0] OP_JPC   = 4'b1101;
    localparam logic [3:0] OP_JPS   = 4'b1110;

    // no-argument words need a clear stack field
    localparam logic [1:0] STK_NONE = 2'b00;

    // bit operations
    localparam logic [2:0] BOP_NONE = 3'b000;
    localparam logic [2:0] BOP_BWS  = 3'b001;
    localparam logic [2:0] BOP_BWC  = 3'b010;
    localparam logic [2:0] BOP_BOS  = 3'b100;
    localparam logic [2:0] BOP_BOC  = 3'b101;
    localparam logic [2:0] BOP_BIJ  = 3'b110;

    // no-argument sub-operations
    localparam logic [3:0] SOP_INC  = 4'b0001;
    localparam logic [3:0] SOP_DEC  = 4'b0010;
    localparam logic [3:0] SOP_RTL  = 4'b0011;
    localparam logic [3:0] SOP_RTR  = 4'b0100;
    localparam logic [3:0] SOP_NOT  = 4'b0101;
    localparam logic [3:0] SOP_COM  = 4'b0110;
    localparam logic [3:0] SOP_MWO  = 4'b1001;
    localparam logic [3:0] SOP_MIW  = 4'b1010;
    localparam logic [3:0] SOP_CLW  = 4'b1011;
    localparam logic [3:0] SOP_CLO  = 4'b1100;
    localparam logic [3:0] SOP_HLT  = 4'b1101;

    // flag vector positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_S = 2;

    typedef union packed {
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] addr;
        } mem;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] stack;
            logic [2:0] spare;
            logic [2:0] bop;
            logic [3:0] sub;
        } noarg;
    } instr_u;

endpackage

`default_nettype wire
